// File: hw/armPkg.sv
`default_nettype none

package armPkg;

	// instruction field positions.
	localparam int condFieldHi = 31;
	localparam int condFieldLo = 28;
	localparam int opHi = 27;
	localparam int opLo = 26;
	localparam int functHi = 25;
	localparam int functLo = 20;
	localparam int iBit = 25;
	localparam int cmdHi = 24;
	localparam int cmdLo = 21;
	localparam int sBit = 20;
	localparam int rnHi = 19;
	localparam int rnLo = 16;
	localparam int rdHi = 15;
	localparam int rdLo = 12;
	localparam int rotHi = 11;
	localparam int rotLo = 8;
	localparam int imm8Hi = 7;
	localparam int imm8Lo = 0;
	localparam int rmHi = 3;
	localparam int rmLo = 0;
	localparam int imm24Hi = 23;

	localparam logic [1:0] opDp = 2'b00;
	localparam logic [1:0] opBranch = 2'b10;

	// data-processing cmd field.
	localparam logic [3:0] cmdAnd = 4'b0000;
	localparam logic [3:0] cmdEor = 4'b0001;
	localparam logic [3:0] cmdSub = 4'b0010;
	localparam logic [3:0] cmdRsb = 4'b0011;
	localparam logic [3:0] cmdAdd = 4'b0100;
	localparam logic [3:0] cmdCmp = 4'b1010;
	localparam logic [3:0] cmdOrr = 4'b1100;
	localparam logic [3:0] cmdMov = 4'b1101;

	typedef enum logic [2:0] {
		aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluOrr, aluMov
	} aluOpT;

	typedef enum logic {
		immDp,
		immBranch
	} immSrcT;

	typedef enum logic [3:0] {
		condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
		condHi, condLs, condGe, condLt, condGt, condLe, condAl
	} condT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcImm;
		logic regWrite;
		logic setFlags;
		logic isBranch;
		logic regSrcA; // first port reads r15.
		logic regSrcB; // second port reads Rd.
		immSrcT immSrc;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [3:0] cond;
		ctrlT ctrl;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] ext;
		logic [3:0] wa;
		logic [31:0] pcPlus8;
	} decExT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic [3:0] wa;
		logic [31:0] result;
		logic branchTaken;
		logic [31:0] branchTarget;
	} exWbT;

endpackage

`default_nettype wire

// File: hw/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic [1:0] op,
	input logic [5:0] funct,
	output armPkg::ctrlT ctrl
);
	import armPkg::*;

	logic [3:0] cmd;

	assign cmd = funct[cmdHi - functLo:cmdLo - functLo];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluMov;
		ctrl.immSrc = immDp;
		case (op)
			opDp: begin
				ctrl.aluSrcImm = funct[iBit - functLo];
				ctrl.setFlags = funct[sBit - functLo];
				ctrl.regWrite = 1'b1;
				case (cmd)
					cmdAnd: ctrl.aluOp = aluAnd;
					cmdEor: ctrl.aluOp = aluEor;
					cmdSub: ctrl.aluOp = aluSub;
					cmdRsb: ctrl.aluOp = aluRsb;
					cmdAdd: ctrl.aluOp = aluAdd;
					cmdOrr: ctrl.aluOp = aluOrr;
					cmdMov: ctrl.aluOp = aluMov;
					cmdCmp: begin
						ctrl.aluOp = aluSub;
						ctrl.regWrite = 1'b0; // flags only.
						ctrl.setFlags = 1'b1;
					end
					default: begin
						ctrl.regWrite = 1'b0; // unsupported cmd is a no-op.
						ctrl.setFlags = 1'b0;
					end
				endcase
			end
			opBranch: begin
				ctrl.aluOp = aluAdd; // pc+8 plus offset.
				ctrl.aluSrcImm = 1'b1;
				ctrl.isBranch = 1'b1;
				ctrl.regSrcA = 1'b1;
				ctrl.regSrcB = 1'b1; // port two is unused by B.
				ctrl.immSrc = immBranch;
			end
			default: begin
				ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/immExtend.sv
`timescale 1ns/1ps
`default_nettype none

module immExtend (
	input logic [23:0] imm,
	input armPkg::immSrcT immSrc,
	output logic [31:0] ext
);
	import armPkg::*;

	logic [31:0] imm8Z;
	logic [4:0] rotAmt;
	logic [63:0] rotated;

	assign imm8Z = {24'b0, imm[imm8Hi:imm8Lo]};
	assign rotAmt = {imm[rotHi:rotLo], 1'b0}; // twice rot.

	// rotate right through a doubled copy.
	assign rotated = {imm8Z, imm8Z} >> rotAmt;

	always_comb begin
		case (immSrc)
			immBranch: ext = {{6{imm[23]}}, imm, 2'b00}; // word offset.
			default: ext = rotated[31:0];
		endcase
	end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic rstN,
	input logic we,
	input logic [3:0] wa,
	input logic [3:0] ra1,
	input logic [3:0] ra2,
	input logic [31:0] wd,
	input logic [31:0] pcPlus8,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:14]; // r0 to r14.

	always_ff @(posedge clk) begin
		if (we && wa != 4'd15) begin
			regs[wa] <= wd;
		end
	end

	// r15 first, then the write in flight, then the array.
	assign rd1 = (ra1 == 4'd15) ? pcPlus8 :
		(we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 4'd15) ? pcPlus8 :
		(we && wa == ra2) ? wd : regs[ra2];

	// the control unit never targets the PC.
	noPcWrite: assert property (@(posedge clk) disable iff (!rstN)
		we |-> wa != 4'd15)
		else $error("register file write to r15");

endmodule

`default_nettype wire

// File: hw/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input payloadT d,
	output payloadT q
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= '0; // clears valid too.
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [31:0] instr,
	input logic [31:0] pcPlus8,
	input logic weW,
	input logic [3:0] waW,
	input logic [31:0] wdW,
	output armPkg::decExT de
);
	import armPkg::*;

	ctrlT ctrl;
	logic [3:0] rn, rd, rm;
	logic [3:0] ra1, ra2;
	logic [31:0] rdA, rdB;
	logic [31:0] ext;

	assign rn = instr[rnHi:rnLo];
	assign rd = instr[rdHi:rdLo];
	assign rm = instr[rmHi:rmLo];

	controlUnit ctrlUnit (
		.op(instr[opHi:opLo]),
		.funct(instr[functHi:functLo]),
		.ctrl(ctrl)
	);

	assign ra1 = ctrl.regSrcA ? 4'd15 : rn;
	assign ra2 = ctrl.regSrcB ? rd : rm;

	immExtend immExt (
		.imm(instr[imm24Hi:0]),
		.immSrc(ctrl.immSrc),
		.ext(ext)
	);

	registerFile regFile (
		.clk(clk),
		.rstN(rstN),
		.we(weW),
		.wa(waW),
		.ra1(ra1),
		.ra2(ra2),
		.wd(wdW),
		.pcPlus8(pcPlus8),
		.rd1(rdA),
		.rd2(rdB)
	);

	always_comb begin
		de.valid = instrValid;
		de.cond = instr[condFieldHi:condFieldLo];
		de.ctrl = ctrl;
		de.rd1 = rdA;
		de.rd2 = rdB;
		de.ext = ext;
		de.wa = rd; // destination is always Rd.
		de.pcPlus8 = pcPlus8;
	end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rstN,
	input armPkg::decExT de,
	output armPkg::exWbT ew,
	output armPkg::flagsT flags
);
	import armPkg::*;

	flagsT flagsQ;
	flagsT aluFlags;
	logic condEx;
	logic arith;
	logic cin;
	logic [31:0] srcA, srcB;
	logic [31:0] addX, addY;
	logic [32:0] sum;
	logic [31:0] result;

	always_comb begin
		case (condT'(de.cond))
			condEq: condEx = flagsQ.z;
			condNe: condEx = !flagsQ.z;
			condCs: condEx = flagsQ.c;
			condCc: condEx = !flagsQ.c;
			condMi: condEx = flagsQ.n;
			condPl: condEx = !flagsQ.n;
			condVs: condEx = flagsQ.v;
			condVc: condEx = !flagsQ.v;
			condHi: condEx = flagsQ.c && !flagsQ.z;
			condLs: condEx = !flagsQ.c || flagsQ.z;
			condGe: condEx = flagsQ.n == flagsQ.v;
			condLt: condEx = flagsQ.n != flagsQ.v;
			condGt: condEx = !flagsQ.z && (flagsQ.n == flagsQ.v);
			condLe: condEx = flagsQ.z || (flagsQ.n != flagsQ.v);
			condAl: condEx = 1'b1;
			default: condEx = 1'b0; // 4'b1111 never executes.
		endcase
	end

	assign srcA = de.rd1;
	assign srcB = de.ctrl.aluSrcImm ? de.ext : de.rd2;

	// one adder for add, sub and rsb.
	always_comb begin
		addX = srcA;
		addY = srcB;
		cin = 1'b0;
		arith = 1'b0;
		case (de.ctrl.aluOp)
			aluSub: begin
				addY = ~srcB;
				cin = 1'b1;
				arith = 1'b1;
			end
			aluRsb: begin
				addX = srcB;
				addY = ~srcA;
				cin = 1'b1;
				arith = 1'b1;
			end
			aluAdd: arith = 1'b1;
			default: ;
		endcase
	end

	assign sum = {1'b0, addX} + {1'b0, addY} + {32'b0, cin};

	always_comb begin
		case (de.ctrl.aluOp)
			aluAnd: result = srcA & srcB;
			aluEor: result = srcA ^ srcB;
			aluOrr: result = srcA | srcB;
			aluMov: result = srcB;
			default: result = sum[31:0];
		endcase
	end

	// logical ops leave c and v alone.
	always_comb begin
		aluFlags.n = result[31];
		aluFlags.z = (result == 32'd0);
		aluFlags.c = arith ? sum[32] : flagsQ.c;
		aluFlags.v = arith ? (addX[31] == addY[31]) && (sum[31] != addX[31]) : flagsQ.v;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else if (de.valid && condEx && de.ctrl.setFlags) begin
			flagsQ <= aluFlags;
		end
	end

	always_comb begin
		ew.valid = de.valid;
		ew.regWrite = condEx && de.ctrl.regWrite;
		ew.wa = de.wa;
		ew.result = result;
		ew.branchTaken = condEx && de.ctrl.isBranch;
		ew.branchTarget = result;
	end

	assign flags = flagsQ;

	flagsKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(flagsQ))
		else $error("flags unknown");

endmodule

`default_nettype wire

// File: hw/armCore.sv
`timescale 1ns/1ps
`default_nettype none

module armCore (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [31:0] instr,
	input logic [31:0] pcPlus8,
	output logic wbValid,
	output logic [3:0] wbAddr,
	output logic [31:0] wbData,
	output logic branchTaken,
	output logic [31:0] branchTarget,
	output armPkg::flagsT flags
);
	import armPkg::*;

	decExT deD, deE;
	exWbT ewE, ewW;
	logic weW;

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pcPlus8(pcPlus8),
		.weW(weW),
		.waW(ewW.wa),
		.wdW(ewW.result),
		.de(deD)
	);

	pipeReg #(.payloadT(decExT)) deReg (.clk(clk), .rstN(rstN), .d(deD), .q(deE));

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.de(deE),
		.ew(ewE),
		.flags(flags)
	);

	pipeReg #(.payloadT(exWbT)) ewReg (.clk(clk), .rstN(rstN), .d(ewE), .q(ewW));

	assign weW = ewW.valid && ewW.regWrite;
	assign wbValid = weW;
	assign wbAddr = ewW.wa;
	assign wbData = ewW.result;
	assign branchTaken = ewW.valid && ewW.branchTaken;
	assign branchTarget = ewW.branchTarget;

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	// 100 ns period.
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#1 rstN = 1'b1; // released just after the second edge.
	end

endmodule

`default_nettype wire

// File: verification/armCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;
	import armPkg::*;

	typedef struct packed {
		logic [31:0] due;
		logic we;
		logic [3:0] wa;
		logic [31:0] wd;
		logic br;
		logic [31:0] target;
		flagsT flags;
	} expT;

	localparam int numAlu = 6;
	localparam int numCmp = 16;
	localparam int numCond = 60;
	localparam int numBr = 12;
	localparam int totalInstr = 15 + 6 + 6 * 2 * numAlu + numCmp + numCond + 2 * numBr;
	localparam int timeoutCycles = totalInstr * 4 + 50;
	localparam logic [3:0] dpCmds [8] = '{cmdAnd, cmdEor, cmdSub, cmdRsb,
		cmdAdd, cmdOrr, cmdMov, cmdCmp};

	logic clk, rstN;
	logic instrValid;
	logic [31:0] instr, pcPlus8;
	logic wbValid, branchTaken;
	logic [3:0] wbAddr;
	logic [31:0] wbData, branchTarget;
	flagsT flags;

	int seed = 32'h7efe;
	int cycle = 0;
	logic [31:0] pc;
	logic [31:0] modelRegs [0:14];
	flagsT modelFlags;
	flagsT lastFlags;
	expT expQ [$];
	expT seen;

	clockGen clkGen (.clk(clk), .rstN(rstN));

	armCore dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pcPlus8(pcPlus8),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.flags(flags)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic mismatch(input string what);
		failRun($sformatf("mismatch at %0t: %s", $time, what));
	endtask

	function automatic logic [31:0] rorImm(input logic [7:0] imm8, input logic [3:0] rot);
		logic [31:0] x;
		logic [4:0] amt;
		x = {24'h0, imm8};
		amt = {rot, 1'b0};
		return (x >> amt) | (x << (6'd32 - {1'b0, amt}));
	endfunction

	function automatic logic condPasses(input logic [3:0] cond, input flagsT f);
		case (cond)
			4'h0: return f.z;
			4'h1: return !f.z;
			4'h2: return f.c;
			4'h3: return !f.c;
			4'h4: return f.n;
			4'h5: return !f.n;
			4'h6: return f.v;
			4'h7: return !f.v;
			4'h8: return f.c && !f.z;
			4'h9: return !(f.c && !f.z);
			4'ha: return f.n == f.v;
			4'hb: return f.n != f.v;
			4'hc: return !f.z && f.n == f.v;
			4'hd: return f.z || f.n != f.v;
			default: return cond == 4'he; // always.
		endcase
	endfunction

	function automatic logic [31:0] readReg(input logic [3:0] r);
		return (r == 4'd15) ? pc + 32'd8 : modelRegs[r];
	endfunction

	function automatic logic [3:0] pickReg(input logic [31:0] r, input logic allowPc);
		if (allowPc && r[7:5] == 3'd0) begin
			return 4'd15;
		end
		return r[3:0] % 4'd15;
	endfunction

	// reference ALU with c as no-borrow on subtraction.
	task automatic computeAlu(input logic [3:0] cmd, input logic [31:0] a, input logic [31:0] b,
		output logic [31:0] res, output flagsT nf);
		logic [32:0] wide;
		nf = modelFlags;
		case (cmd)
			cmdAnd: res = a & b;
			cmdEor: res = a ^ b;
			cmdOrr: res = a | b;
			cmdMov: res = b;
			cmdAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[31:0];
				nf.c = wide[32];
				nf.v = (a[31] == b[31]) && (res[31] != a[31]);
			end
			cmdSub, cmdCmp: begin
				res = a - b;
				nf.c = a >= b;
				nf.v = (a[31] != b[31]) && (res[31] != a[31]);
			end
			cmdRsb: begin
				res = b - a;
				nf.c = b >= a;
				nf.v = (a[31] != b[31]) && (res[31] != b[31]);
			end
			default: res = 32'h0;
		endcase
		nf.n = res[31];
		nf.z = (res == 32'h0);
	endtask

	// drive one instruction, then leave one idle slot.
	task automatic sendInstr(input logic [31:0] word, input expT e);
		e.due = cycle + 2;
		expQ.push_back(e);
		instr = word;
		pcPlus8 = pc + 32'd8;
		instrValid = 1'b1;
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		instr = 32'h0;
		@(posedge clk);
		#1;
	endtask

	task automatic dataProc(input logic [3:0] cond, input logic [3:0] cmd, input logic s,
		input logic immForm, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm,
		input logic [7:0] imm8, input logic [3:0] rot);
		logic [11:0] op2;
		logic [31:0] a, b, res;
		flagsT nf;
		expT e;
		logic pass;
		op2 = immForm ? {rot, imm8} : {8'h00, rm};
		a = readReg(rn);
		b = immForm ? rorImm(imm8, rot) : readReg(rm);
		computeAlu(cmd, a, b, res, nf);
		pass = condPasses(cond, modelFlags);
		e = '0;
		e.we = pass && cmd != cmdCmp;
		e.wa = rd;
		e.wd = res;
		if (pass && (s || cmd == cmdCmp)) begin
			modelFlags = nf;
		end
		e.flags = modelFlags;
		if (e.we) begin
			modelRegs[rd] = res;
		end
		sendInstr({cond, 2'b00, immForm, cmd, s || cmd == cmdCmp, rn, rd, op2}, e);
		pc = pc + 32'd4;
	endtask

	task automatic branch(input logic [3:0] cond, input logic [23:0] imm24);
		expT e;
		e = '0;
		e.br = condPasses(cond, modelFlags);
		e.target = pc + 32'd8 + (32'($signed(imm24)) << 2);
		e.flags = modelFlags;
		sendInstr({cond, 4'b1010, imm24}, e);
		pc = e.br ? e.target : pc + 32'd4;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// outputs are compared mid-cycle.
	always @(negedge clk) begin
		if (rstN) begin
			if (expQ.size() != 0 && expQ[0].due == cycle) begin
				seen = expQ.pop_front();
				assert (wbValid == seen.we) else mismatch($sformatf("wbValid %b expected %b",
					wbValid, seen.we));
				if (seen.we) begin
					assert (wbAddr == seen.wa) else mismatch($sformatf(
						"wbAddr %0d expected %0d", wbAddr, seen.wa));
					assert (wbData == seen.wd) else mismatch($sformatf(
						"wbData %h expected %h", wbData, seen.wd));
				end
				assert (branchTaken == seen.br) else mismatch($sformatf(
					"branchTaken %b expected %b", branchTaken, seen.br));
				if (seen.br) begin
					assert (branchTarget == seen.target) else mismatch($sformatf(
						"branchTarget %h expected %h", branchTarget, seen.target));
				end
				assert (flags == seen.flags) else mismatch($sformatf(
					"flags %b expected %b", flags, seen.flags));
				lastFlags = seen.flags;
			end else begin
				assert (!wbValid) else mismatch("wbValid high with no writeback due");
				assert (!branchTaken) else mismatch("branchTaken high with no branch due");
				assert (flags == lastFlags) else mismatch($sformatf(
					"idle flags %b expected %b", flags, lastFlags));
			end
		end
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		failRun("watchdog expired before the test sequence finished");
	end

	initial begin
		int i, j;
		logic [31:0] rnd, rnd2;
		instrValid = 1'b0;
		instr = 32'h0;
		pcPlus8 = 32'h0;
		pc = 32'h1000;
		modelFlags = '0;
		lastFlags = '0;
		@(posedge rstN);
		repeat (3) @(posedge clk); // idle after reset.
		#1;
		for (i = 0; i < 15; i++) begin
			rnd = $random(seed);
			dataProc(condAl, cmdMov, 1'b0, 1'b1, 4'd0, 4'(i), 4'd0, rnd[7:0], rnd[11:8]);
		end
		// carry and overflow corners.
		dataProc(condAl, cmdMov, 1'b0, 1'b1, 4'd0, 4'd1, 4'd0, 8'h80, 4'd4);
		dataProc(condAl, cmdMov, 1'b0, 1'b1, 4'd0, 4'd2, 4'd0, 8'h01, 4'd0);
		dataProc(condAl, cmdCmp, 1'b1, 1'b0, 4'd1, 4'd0, 4'd2, 8'h00, 4'd0);
		dataProc(condAl, cmdAdd, 1'b1, 1'b0, 4'd1, 4'd3, 4'd1, 8'h00, 4'd0);
		dataProc(condAl, cmdSub, 1'b1, 1'b0, 4'd2, 4'd4, 4'd1, 8'h00, 4'd0);
		dataProc(condAl, cmdAdd, 1'b1, 1'b1, 4'd2, 4'd5, 4'd0, 8'hff, 4'd0);
		for (i = 0; i < 6; i++) begin
			for (j = 0; j < 2 * numAlu; j++) begin
				rnd = $random(seed);
				rnd2 = $random(seed);
				dataProc(condAl, dpCmds[i], rnd2[12], 1'(j % 2), pickReg(rnd, 1'b1),
					pickReg(rnd >> 12, 1'b0), pickReg(rnd >> 20, 1'b1), rnd2[7:0], rnd2[11:8]);
			end
		end
		for (j = 0; j < numCmp; j++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			dataProc(condAl, cmdCmp, 1'b1, rnd2[13], pickReg(rnd, 1'b1), 4'd0,
				pickReg(rnd >> 12, 1'b1), rnd2[7:0], rnd2[11:8]);
		end
		// every condition code against varied flags.
		for (j = 0; j < numCond; j++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			dataProc(4'(j % 15), dpCmds[rnd2[2:0]], rnd2[12], rnd2[13], pickReg(rnd, 1'b1),
				pickReg(rnd >> 12, 1'b0), pickReg(rnd >> 20, 1'b1), rnd2[23:16], rnd2[27:24]);
		end
		for (j = 0; j < numBr; j++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			dataProc(condAl, cmdCmp, 1'b1, 1'b0, pickReg(rnd, 1'b0), 4'd0,
				pickReg(rnd >> 12, 1'b0), 8'h00, 4'd0);
			branch(rnd2[31:28] % 4'd15, rnd2[23:0]);
		end
		repeat (4) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hw/armPkg.sv
hw/controlUnit.sv
hw/immExtend.sv
hw/registerFile.sv
hw/pipeReg.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/armCore.sv
verification/clockGen.sv
verification/armCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the armCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f all.f --top-module armCoreTb \
	-Mdir obj_dir -o simArmCore
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/simArmCore > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF 'All tests passed!' "$logFile"; then
	exit 0
else
	echo "pass message not found in $logFile"
	exit 1
fi
